// File: cache_pkg.sv
package cache_pkg;

    // cache geometry
    localparam int num_sets   = 8;
    localparam int line_bytes = 16;
    localparam int line_bits  = line_bytes * 8;

    // address split, upper bits are the tag and lower bits the set index
    localparam int index_bits = $clog2(num_sets);
    localparam int tag_bits   = 9;
    localparam int addr_bits  = tag_bits + index_bits;

    // one full line, byte 0 in the low bits
    typedef logic [line_bits-1:0] cache_line_t;

    // line address as seen on both buses
    typedef logic [addr_bits-1:0] cache_addr_t;

    typedef logic [tag_bits-1:0] cache_tag_t;

    typedef logic [index_bits-1:0] cache_index_t;

    // one enable per byte of the line
    typedef logic [line_bytes-1:0] byte_sel_t;

    // controller sequencing
    typedef enum logic [1:0] {
        idle,
        compare,
        write_back,
        allocate
    } ctrl_state_t;

endpackage : cache_pkg

// File: cache_ctrl_if.sv
`timescale 1ns/1ps

interface cache_ctrl_if;

    // controller to datapath
    logic way_sel;
    logic data_source_sel;
    logic tag_bypass_sel;
    logic load;
    logic load_lru;

    // datapath to controller
    logic hit_0;
    logic hit_1;
    logic dirty;
    logic lru;

    modport ctrl (
        output way_sel,
        output data_source_sel,
        output tag_bypass_sel,
        output load,
        output load_lru,
        input  hit_0,
        input  hit_1,
        input  dirty,
        input  lru
    );

    modport dp (
        input  way_sel,
        input  data_source_sel,
        input  tag_bypass_sel,
        input  load,
        input  load_lru,
        output hit_0,
        output hit_1,
        output dirty,
        output lru
    );

endinterface : cache_ctrl_if

// File: cache_way.sv
`timescale 1ns/1ps

module cache_way (
    input  logic                    clk,
    input  logic                    arst_n,
    input  logic                    load,
    input  logic                    load_type,
    input  cache_pkg::byte_sel_t    byte_sel,
    input  cache_pkg::cache_tag_t   tag_in,
    input  cache_pkg::cache_index_t index,
    input  cache_pkg::cache_line_t  data_in,
    output cache_pkg::cache_tag_t   tag_out,
    output cache_pkg::cache_line_t  data_out,
    output logic                    dirty_out,
    output logic                    hit_out
);
    import cache_pkg::*;

    cache_line_t         data_arr [num_sets];
    cache_tag_t          tag_arr  [num_sets];
    logic [num_sets-1:0] valid_bits;
    logic [num_sets-1:0] dirty_bits;
    cache_line_t         merged_line;

    // stored line with the enabled bytes replaced
    always_comb begin
        merged_line = data_arr[index];
        for (int i = 0; i < line_bytes; i++) begin
            if (byte_sel[i]) begin
                merged_line[i*8 +: 8] = data_in[i*8 +: 8];
            end
        end
    end

    // status bits per set
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            valid_bits <= '0;
            dirty_bits <= '0;
        end else if (load) begin
            if (load_type) begin
                // fill from memory leaves the line clean
                valid_bits[index] <= 1'b1;
                dirty_bits[index] <= 1'b0;
            end else begin
                dirty_bits[index] <= 1'b1;
            end
        end
    end

    // line and tag storage
    always_ff @(posedge clk) begin
        if (load) begin
            if (load_type) begin
                data_arr[index] <= data_in;
                tag_arr[index]  <= tag_in;
            end else begin
                data_arr[index] <= merged_line;
            end
        end
    end

    assign tag_out   = tag_arr[index];
    assign data_out  = data_arr[index];
    assign dirty_out = dirty_bits[index];

    // hit needs a valid line with a matching tag
    assign hit_out = valid_bits[index] && (tag_arr[index] == tag_in);

endmodule : cache_way

// File: cache_l1_datapath.sv
`timescale 1ns/1ps

module cache_l1_datapath (
    input  logic                   clk,
    input  logic                   arst_n,
    cache_ctrl_if.dp               ctrl,
    input  cache_pkg::cache_addr_t cpu_adr,
    input  cache_pkg::byte_sel_t   cpu_sel,
    input  cache_pkg::cache_line_t cpu_dat_w,
    input  cache_pkg::cache_line_t mem_dat_r,
    output cache_pkg::cache_line_t cpu_dat_r,
    output cache_pkg::cache_addr_t mem_adr,
    output cache_pkg::byte_sel_t   mem_sel,
    output cache_pkg::cache_line_t mem_dat_w
);
    import cache_pkg::*;

    cache_tag_t   req_tag;
    cache_index_t index;

    cache_line_t  wr_data;
    byte_sel_t    wr_sel;
    logic         load_0;
    logic         load_1;

    cache_tag_t   tag_0;
    cache_tag_t   tag_1;
    cache_line_t  data_0;
    cache_line_t  data_1;
    logic         dirty_0;
    logic         dirty_1;

    cache_line_t  way_data;
    cache_tag_t   victim_tag;
    cache_tag_t   out_tag;

    logic [num_sets-1:0] lru_bits;

    // split the request address
    assign req_tag = cpu_adr[addr_bits-1 -: tag_bits];
    assign index   = cpu_adr[index_bits-1:0];

    // memory transfers always move a whole line
    assign mem_sel = '1;

    // write source, processor merge or memory fill
    assign wr_data = ctrl.data_source_sel ? mem_dat_r : cpu_dat_w;
    assign wr_sel  = ctrl.data_source_sel ? mem_sel : cpu_sel;

    // load goes only to the selected way
    assign load_0 = ctrl.load & ~ctrl.way_sel;
    assign load_1 = ctrl.load &  ctrl.way_sel;

    cache_way way_0 (
        .clk       (clk),
        .arst_n    (arst_n),
        .load      (load_0),
        .load_type (ctrl.data_source_sel),
        .byte_sel  (wr_sel),
        .tag_in    (req_tag),
        .index     (index),
        .data_in   (wr_data),
        .tag_out   (tag_0),
        .data_out  (data_0),
        .dirty_out (dirty_0),
        .hit_out   (ctrl.hit_0)
    );

    cache_way way_1 (
        .clk       (clk),
        .arst_n    (arst_n),
        .load      (load_1),
        .load_type (ctrl.data_source_sel),
        .byte_sel  (wr_sel),
        .tag_in    (req_tag),
        .index     (index),
        .data_in   (wr_data),
        .tag_out   (tag_1),
        .data_out  (data_1),
        .dirty_out (dirty_1),
        .hit_out   (ctrl.hit_1)
    );

    // same line feeds the processor read and the write-back
    assign way_data  = ctrl.way_sel ? data_1 : data_0;
    assign cpu_dat_r = way_data;
    assign mem_dat_w = way_data;

    // victim address on write-back, request address on fill
    assign victim_tag = ctrl.way_sel ? tag_1 : tag_0;
    assign out_tag    = ctrl.tag_bypass_sel ? req_tag : victim_tag;
    assign mem_adr    = {out_tag, index};

    // lru bit names the way to evict next
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            lru_bits <= '0;
        end else if (ctrl.load_lru) begin
            lru_bits[index] <= ~ctrl.way_sel;
        end
    end

    assign ctrl.lru   = lru_bits[index];
    assign ctrl.dirty = lru_bits[index] ? dirty_1 : dirty_0;

endmodule : cache_l1_datapath

// File: cache_l1_controller.sv
`timescale 1ns/1ps

module cache_l1_controller (
    input  logic       clk,
    input  logic       arst_n,
    input  logic       cpu_cyc,
    input  logic       cpu_stb,
    input  logic       cpu_we,
    input  logic       mem_ack,
    output logic       cpu_ack,
    output logic       mem_cyc,
    output logic       mem_stb,
    output logic       mem_we,
    cache_ctrl_if.ctrl ctrl
);
    import cache_pkg::*;

    ctrl_state_t state;
    ctrl_state_t next_state;
    logic        hit;

    assign hit = ctrl.hit_0 | ctrl.hit_1;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= idle;
        end else begin
            state <= next_state;
        end
    end

    // next state
    always_comb begin
        next_state = state;
        case (state)
            idle: begin
                if (cpu_cyc && cpu_stb) begin
                    next_state = compare;
                end
            end
            compare: begin
                if (hit) begin
                    next_state = idle;
                end else if (ctrl.dirty) begin
                    next_state = write_back;
                end else begin
                    next_state = allocate;
                end
            end
            write_back: begin
                if (mem_ack) begin
                    next_state = allocate;
                end
            end
            allocate: begin
                // back to compare, which then hits on the new line
                if (mem_ack) begin
                    next_state = compare;
                end
            end
            default: begin
                next_state = idle;
            end
        endcase
    end

    // outputs and datapath selects
    always_comb begin
        cpu_ack              = 1'b0;
        mem_cyc              = 1'b0;
        mem_stb              = 1'b0;
        mem_we               = 1'b0;
        ctrl.way_sel         = ctrl.lru;
        ctrl.data_source_sel = 1'b0;
        ctrl.tag_bypass_sel  = 1'b1;
        ctrl.load            = 1'b0;
        ctrl.load_lru        = 1'b0;
        case (state)
            compare: begin
                if (hit) begin
                    // serve from the hitting way, lru moves to the other one
                    ctrl.way_sel  = ctrl.hit_1;
                    cpu_ack       = 1'b1;
                    ctrl.load     = cpu_we;
                    ctrl.load_lru = 1'b1;
                end
            end
            write_back: begin
                mem_cyc             = 1'b1;
                mem_stb             = 1'b1;
                mem_we              = 1'b1;
                ctrl.tag_bypass_sel = 1'b0;
            end
            allocate: begin
                mem_cyc              = 1'b1;
                mem_stb              = 1'b1;
                ctrl.data_source_sel = 1'b1;
                ctrl.load            = mem_ack;
            end
            default: begin
            end
        endcase
    end

endmodule : cache_l1_controller

// File: cache_l1.sv
`timescale 1ns/1ps

module cache_l1 (
    input  logic                   clk,
    input  logic                   arst_n,

    // processor bus
    input  logic                   cpu_cyc,
    input  logic                   cpu_stb,
    input  logic                   cpu_we,
    input  cache_pkg::cache_addr_t cpu_adr,
    input  cache_pkg::byte_sel_t   cpu_sel,
    input  cache_pkg::cache_line_t cpu_dat_w,
    output cache_pkg::cache_line_t cpu_dat_r,
    output logic                   cpu_ack,

    // memory bus
    output logic                   mem_cyc,
    output logic                   mem_stb,
    output logic                   mem_we,
    output cache_pkg::cache_addr_t mem_adr,
    output cache_pkg::byte_sel_t   mem_sel,
    output cache_pkg::cache_line_t mem_dat_w,
    input  cache_pkg::cache_line_t mem_dat_r,
    input  logic                   mem_ack
);

    cache_ctrl_if ctrl_bus ();

    cache_l1_controller controller (
        .clk     (clk),
        .arst_n  (arst_n),
        .cpu_cyc (cpu_cyc),
        .cpu_stb (cpu_stb),
        .cpu_we  (cpu_we),
        .mem_ack (mem_ack),
        .cpu_ack (cpu_ack),
        .mem_cyc (mem_cyc),
        .mem_stb (mem_stb),
        .mem_we  (mem_we),
        .ctrl    (ctrl_bus.ctrl)
    );

    cache_l1_datapath datapath (
        .clk       (clk),
        .arst_n    (arst_n),
        .ctrl      (ctrl_bus.dp),
        .cpu_adr   (cpu_adr),
        .cpu_sel   (cpu_sel),
        .cpu_dat_w (cpu_dat_w),
        .mem_dat_r (mem_dat_r),
        .cpu_dat_r (cpu_dat_r),
        .mem_adr   (mem_adr),
        .mem_sel   (mem_sel),
        .mem_dat_w (mem_dat_w)
    );

endmodule : cache_l1

// File: tb_main_memory.sv
`timescale 1ns/1ps

module tb_main_memory #(
    parameter int ack_delay = 3
) (
    input  logic                   clk,
    input  logic                   arst_n,
    input  logic                   mem_cyc,
    input  logic                   mem_stb,
    input  logic                   mem_we,
    input  cache_pkg::cache_addr_t mem_adr,
    input  cache_pkg::byte_sel_t   mem_sel,
    input  cache_pkg::cache_line_t mem_dat_w,
    output cache_pkg::cache_line_t mem_dat_r,
    output logic                   mem_ack,
    output int                     rd_count,
    output int                     wr_count,
    output cache_pkg::cache_addr_t last_rd_adr,
    output cache_pkg::cache_addr_t last_wr_adr,
    output cache_pkg::cache_line_t last_wr_dat
);
    import cache_pkg::*;

    cache_line_t mem [1 << addr_bits];
    int          wait_cnt;

    // halfword h of a line holds the line address and h
    function automatic cache_line_t line_pattern(cache_addr_t adr);
        cache_line_t line;
        for (int h = 0; h < 8; h++) begin
            line[h*16 +: 16] = {adr, 4'(h)};
        end
        return line;
    endfunction

    function automatic cache_line_t apply_sel(cache_line_t old_line, cache_line_t new_line,
                                              byte_sel_t sel);
        cache_line_t line;
        line = old_line;
        for (int i = 0; i < line_bytes; i++) begin
            if (sel[i]) begin
                line[i*8 +: 8] = new_line[i*8 +: 8];
            end
        end
        return line;
    endfunction

    initial begin
        for (int a = 0; a < (1 << addr_bits); a++) begin
            mem[a] = line_pattern(cache_addr_t'(a));
        end
    end

    // count cycles with stb up, then answer with a one-cycle ack
    always @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            mem_ack     <= 1'b0;
            wait_cnt    <= 0;
            rd_count    <= 0;
            wr_count    <= 0;
            last_rd_adr <= '0;
            last_wr_adr <= '0;
            last_wr_dat <= '0;
        end else begin
            mem_ack <= 1'b0;
            if (mem_cyc && mem_stb && !mem_ack) begin
                if (wait_cnt == ack_delay - 1) begin
                    wait_cnt <= 0;
                    mem_ack  <= 1'b1;
                    if (mem_we) begin
                        mem[mem_adr] <= apply_sel(mem[mem_adr], mem_dat_w, mem_sel);
                        wr_count     <= wr_count + 1;
                        last_wr_adr  <= mem_adr;
                        last_wr_dat  <= mem_dat_w;
                        $display("memory: write-back of line %h at %0t", mem_adr, $time);
                    end else begin
                        mem_dat_r   <= mem[mem_adr];
                        rd_count    <= rd_count + 1;
                        last_rd_adr <= mem_adr;
                    end
                end else begin
                    wait_cnt <= wait_cnt + 1;
                end
            end
        end
    end

endmodule : tb_main_memory

// File: tb_cache_l1.sv
`timescale 1ns/1ps

module tb_cache_l1 #(
    parameter int num_entries  = 15,
    parameter int entry_cycles = 40,
    parameter int reset_cycles = 5
);
    import cache_pkg::*;

    // one stimulus row, the counts are the memory transfers it should cause
    typedef struct packed {
        logic        we;
        cache_addr_t adr;
        byte_sel_t   sel;
        logic [1:0]  rd_ops;
        logic [1:0]  wr_ops;
        cache_addr_t wb_adr;
    } entry_t;

    logic        clk;
    logic        arst_n;
    logic        cpu_cyc;
    logic        cpu_stb;
    logic        cpu_we;
    logic        cpu_ack;
    cache_addr_t cpu_adr;
    byte_sel_t   cpu_sel;
    cache_line_t cpu_dat_w;
    cache_line_t cpu_dat_r;
    logic        mem_cyc;
    logic        mem_stb;
    logic        mem_we;
    logic        mem_ack;
    cache_addr_t mem_adr;
    byte_sel_t   mem_sel;
    cache_line_t mem_dat_w;
    cache_line_t mem_dat_r;
    int          rd_count;
    int          wr_count;
    cache_addr_t last_rd_adr;
    cache_addr_t last_wr_adr;
    cache_line_t last_wr_dat;

    entry_t      stim [num_entries];
    cache_line_t wdata [num_entries];
    cache_line_t model_mem [1 << addr_bits];
    int          seed;
    int          cycle_count = 0;

    cache_l1 UUT (
        .clk       (clk),
        .arst_n    (arst_n),
        .cpu_cyc   (cpu_cyc),
        .cpu_stb   (cpu_stb),
        .cpu_we    (cpu_we),
        .cpu_adr   (cpu_adr),
        .cpu_sel   (cpu_sel),
        .cpu_dat_w (cpu_dat_w),
        .cpu_dat_r (cpu_dat_r),
        .cpu_ack   (cpu_ack),
        .mem_cyc   (mem_cyc),
        .mem_stb   (mem_stb),
        .mem_we    (mem_we),
        .mem_adr   (mem_adr),
        .mem_sel   (mem_sel),
        .mem_dat_w (mem_dat_w),
        .mem_dat_r (mem_dat_r),
        .mem_ack   (mem_ack)
    );

    tb_main_memory memory (
        .clk         (clk),
        .arst_n      (arst_n),
        .mem_cyc     (mem_cyc),
        .mem_stb     (mem_stb),
        .mem_we      (mem_we),
        .mem_adr     (mem_adr),
        .mem_sel     (mem_sel),
        .mem_dat_w   (mem_dat_w),
        .mem_dat_r   (mem_dat_r),
        .mem_ack     (mem_ack),
        .rd_count    (rd_count),
        .wr_count    (wr_count),
        .last_rd_adr (last_rd_adr),
        .last_wr_adr (last_wr_adr),
        .last_wr_dat (last_wr_dat)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task stop_with_failure();
        $display("Finished with errors");
        $fatal(1);
    endtask

    task check_line(input cache_line_t got, input cache_line_t exp, input string what);
        if (got !== exp) begin
            $display("MISMATCH at %0t: %s expected %h got %h", $time, what, exp, got);
            stop_with_failure();
        end
    endtask

    task check_addr(input cache_addr_t got, input cache_addr_t exp, input string what);
        if (got !== exp) begin
            $display("MISMATCH at %0t: %s expected %h got %h", $time, what, exp, got);
            stop_with_failure();
        end
    endtask

    task check_sel(input byte_sel_t got, input byte_sel_t exp, input string what);
        if (got !== exp) begin
            $display("MISMATCH at %0t: %s expected %h got %h", $time, what, exp, got);
            stop_with_failure();
        end
    endtask

    task check_flag(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            $display("MISMATCH at %0t: %s expected %b got %b", $time, what, exp, got);
            stop_with_failure();
        end
    endtask

    task check_count(input int got, input int exp, input string what);
        if (got != exp) begin
            $display("MISMATCH at %0t: %s expected %0d got %0d", $time, what, exp, got);
            stop_with_failure();
        end
    endtask

    // memory image before any write: halfword h holds the line address and h
    function automatic cache_line_t pattern_line(cache_addr_t adr);
        cache_line_t line;
        for (int h = 0; h < 8; h++) begin
            line[h*16 +: 16] = {adr, 4'(h)};
        end
        return line;
    endfunction

    function automatic cache_line_t merge_bytes(cache_line_t old_line, cache_line_t new_line,
                                                byte_sel_t sel);
        cache_line_t line;
        line = old_line;
        for (int i = 0; i < line_bytes; i++) begin
            if (sel[i]) begin
                line[i*8 +: 8] = new_line[i*8 +: 8];
            end
        end
        return line;
    endfunction

    // counts falling edges until cpu_ack shows up
    task wait_for_ack(output int cycles);
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
            if (cycles > entry_cycles) begin
                $display("no cpu_ack within %0d cycles at time %0t", entry_cycles, $time);
                stop_with_failure();
            end
        end while (cpu_ack !== 1'b1);
    endtask

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= num_entries * entry_cycles + reset_cycles) begin
            $display("timeout: the run went past %0d cycles", cycle_count);
            stop_with_failure();
        end
    end

    // every memory transfer moves a whole line
    always @(negedge clk) begin
        if (arst_n && mem_cyc) begin
            check_sel(mem_sel, 16'hFFFF, "mem_sel during a memory transfer");
        end
    end

    initial begin
        int     cycles;
        int     rd_before;
        int     wr_before;
        entry_t e;

        arst_n    = 1'b0;
        cpu_cyc   = 1'b0;
        cpu_stb   = 1'b0;
        cpu_we    = 1'b0;
        cpu_adr   = '0;
        cpu_sel   = '0;
        cpu_dat_w = '0;
        seed      = 32'h4d686f84;

        // set 3 holds tags 005, 011 and 0a2, line 3c6 sits in set 6
        stim = '{
            '{1'b0, 12'h02B, 16'h0000, 2'd1, 2'd0, 12'h000},
            '{1'b0, 12'h02B, 16'h0000, 2'd0, 2'd0, 12'h000},
            '{1'b1, 12'h02B, 16'h00F3, 2'd0, 2'd0, 12'h000},
            '{1'b0, 12'h02B, 16'h0000, 2'd0, 2'd0, 12'h000},
            '{1'b0, 12'h08B, 16'h0000, 2'd1, 2'd0, 12'h000},
            '{1'b0, 12'h02B, 16'h0000, 2'd0, 2'd0, 12'h000},
            '{1'b0, 12'h08B, 16'h0000, 2'd0, 2'd0, 12'h000},
            '{1'b0, 12'h02B, 16'h0000, 2'd0, 2'd0, 12'h000},
            '{1'b0, 12'h08B, 16'h0000, 2'd0, 2'd0, 12'h000},
            '{1'b0, 12'h513, 16'h0000, 2'd1, 2'd1, 12'h02B},
            '{1'b0, 12'h02B, 16'h0000, 2'd1, 2'd0, 12'h000},
            '{1'b1, 12'h3C6, 16'hA50F, 2'd1, 2'd0, 12'h000},
            '{1'b0, 12'h3C6, 16'h0000, 2'd0, 2'd0, 12'h000},
            '{1'b1, 12'h513, 16'h8001, 2'd0, 2'd0, 12'h000},
            '{1'b0, 12'h513, 16'h0000, 2'd0, 2'd0, 12'h000}
        };
        for (int i = 0; i < num_entries; i++) begin
            wdata[i] = {$random(seed), $random(seed), $random(seed), $random(seed)};
        end
        for (int a = 0; a < (1 << addr_bits); a++) begin
            model_mem[a] = pattern_line(cache_addr_t'(a));
        end

        repeat (reset_cycles) @(negedge clk);
        check_flag(cpu_ack, 1'b0, "cpu_ack after reset");
        check_flag(mem_cyc, 1'b0, "mem_cyc after reset");
        check_flag(mem_stb, 1'b0, "mem_stb after reset");
        check_flag(mem_we, 1'b0, "mem_we after reset");
        arst_n = 1'b1;

        for (int i = 0; i < num_entries; i++) begin
            e = stim[i];
            @(negedge clk);
            rd_before = rd_count;
            wr_before = wr_count;
            cpu_cyc   = 1'b1;
            cpu_stb   = 1'b1;
            cpu_we    = e.we;
            cpu_adr   = e.adr;
            cpu_sel   = e.sel;
            cpu_dat_w = wdata[i];
            wait_for_ack(cycles);
            if (!e.we) begin
                check_line(cpu_dat_r, model_mem[e.adr], $sformatf("read data, entry %0d", i));
            end
            @(negedge clk);
            cpu_cyc = 1'b0;
            cpu_stb = 1'b0;
            cpu_we  = 1'b0;

            if (rd_count - rd_before != int'(e.rd_ops)) begin
                $display("entry %0d caused %0d memory reads where %0d were expected",
                         i, rd_count - rd_before, e.rd_ops);
                stop_with_failure();
            end
            if (wr_count - wr_before != int'(e.wr_ops)) begin
                $display("entry %0d caused %0d memory writes where %0d were expected",
                         i, wr_count - wr_before, e.wr_ops);
                stop_with_failure();
            end
            if (e.rd_ops != 2'd0) begin
                check_addr(last_rd_adr, e.adr, $sformatf("fill address, entry %0d", i));
            end
            if (e.wr_ops != 2'd0) begin
                check_addr(last_wr_adr, e.wb_adr, $sformatf("write-back address, entry %0d", i));
                check_line(last_wr_dat, model_mem[e.wb_adr],
                           $sformatf("write-back data, entry %0d", i));
            end
            // a hit acks in the cycle after the strobe is sampled
            if (e.rd_ops == 2'd0 && e.wr_ops == 2'd0) begin
                check_count(cycles, 1, $sformatf("hit latency, entry %0d", i));
            end
            if (e.we) begin
                model_mem[e.adr] = merge_bytes(model_mem[e.adr], wdata[i], e.sel);
            end
        end

        $display("Finished with no errors");
        $finish;
    end

endmodule : tb_cache_l1

// File: verilog.f
cache_pkg.sv
cache_ctrl_if.sv
cache_way.sv
cache_l1_datapath.sv
cache_l1_controller.sv
cache_l1.sv
tb_main_memory.sv
tb_cache_l1.sv

// File: run_sim.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing -f verilog.f --top-module tb_cache_l1 -o sim_cache_l1

# the simulator status is ignored here, the pass line decides
sim_output=$(./obj_dir/sim_cache_l1 || true)
echo "$sim_output"

if echo "$sim_output" | grep -qx "Finished with no errors"; then
    exit 0
else
    exit 1
fi
